//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wno-fatal
TOP        = mxint_residual_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
PASS_MSG   = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+source
source/mxint_pkg.sv
source/block_fifo.sv
source/split2_with_data.sv
source/mxint_fork2.sv
source/mxint_relu.sv
source/mxint_add.sv
source/mxint_residual_top.sv
tests/mxint_residual_tb.sv

//--- source/block_fifo.sv
`include "mxint_macros.svh"

module block_fifo (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output mxint_pkg::mx_block_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import mxint_pkg::*;

    localparam int ADDR_WIDTH = $clog2(`MX_FIFO_DEPTH);

    // Extra top bit tells full from empty
    typedef logic [ADDR_WIDTH:0] fifo_ptr_t;

    mx_block_t mem [`MX_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      full;
    logic      empty;
    logic      do_write;
    logic      do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[ADDR_WIDTH-1:0]];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy never goes past the depth, so no write lands on a full buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        fifo_ptr_t'(wr_ptr - rd_ptr) <= fifo_ptr_t'(`MX_FIFO_DEPTH))
        else $error("block_fifo occupancy above depth");

    // Nothing shows up at the output without a write
    a_empty_holds: assert property (@(posedge clk) disable iff (reset)
        (empty && !in_valid) |=> empty)
        else $error("block_fifo left empty without a write");

endmodule

//--- source/mxint_add.sv
`include "mxint_macros.svh"

module mxint_add (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t skip,
    input  logic                 skip_valid,
    output logic                 skip_ready,

    input  mxint_pkg::mx_block_t branch,
    input  logic                 branch_valid,
    output logic                 branch_ready,

    output mxint_pkg::mx_block_t sum,
    output logic                 sum_valid,
    input  logic                 sum_ready
);
    import mxint_pkg::*;

    // Arithmetic right shift, saturating at all sign bits
    function automatic man_t align(man_t m, exp_t shift);
        if (shift >= exp_t'(`MX_MAN_WIDTH)) begin
            return m >>> (`MX_MAN_WIDTH - 1);
        end
        return m >>> shift;
    endfunction

    // 9-bit lane sum, halved back into a mantissa
    function automatic man_t lane_add(man_t a, exp_t a_shift, man_t b, exp_t b_shift);
        logic signed [`MX_MAN_WIDTH:0] total;
        total = align(a, a_shift) + align(b, b_shift);
        return total[`MX_MAN_WIDTH:1];
    endfunction

    exp_t      exp_max;
    exp_t      skip_shift;
    exp_t      branch_shift;
    mx_block_t sum_next;
    logic      out_free;
    logic      fire;

    assign exp_max      = (skip.exp > branch.exp) ? skip.exp : branch.exp;
    assign skip_shift   = exp_max - skip.exp;
    assign branch_shift = exp_max - branch.exp;

    always_comb begin
        // One extra bit of range from the halving
        sum_next.exp = exp_max + 1'b1;
        for (int i = 0; i < `MX_BLOCK; i++) begin
            sum_next.man[i] = lane_add(skip.man[i], skip_shift,
                                       branch.man[i], branch_shift);
        end
    end

    // Join: both sides leave together
    assign out_free     = !sum_valid || sum_ready;
    assign skip_ready   = branch_valid && out_free;
    assign branch_ready = skip_valid && out_free;
    assign fire         = skip_valid && branch_valid && out_free;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else if (out_free) begin
            sum_valid <= skip_valid && branch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            sum <= sum_next;
        end
    end

    a_sum_hold: assert property (@(posedge clk) disable iff (reset)
        (sum_valid && !sum_ready) |=> (sum_valid && $stable(sum)))
        else $error("adder output changed while stalled");

endmodule

//--- source/mxint_fork2.sv
module mxint_fork2 (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t data_in_0,
    input  logic                 data_in_0_valid,
    output logic                 data_in_0_ready,

    // FIFO branch
    output mxint_pkg::mx_block_t data_out_0,
    output logic                 data_out_0_valid,
    input  logic                 data_out_0_ready,

    // Straight branch
    output mxint_pkg::mx_block_t data_out_1,
    output logic                 data_out_1_valid,
    input  logic                 data_out_1_ready
);

    split2_with_data u_split (
        .clk                     (clk),
        .reset                   (reset),
        .data_in                 (data_in_0),
        .data_in_valid           (data_in_0_valid),
        .data_in_ready           (data_in_0_ready),
        .fifo_data_out           (data_out_0),
        .fifo_data_out_valid     (data_out_0_valid),
        .fifo_data_out_ready     (data_out_0_ready),
        .straight_data_out       (data_out_1),
        .straight_data_out_valid (data_out_1_valid),
        .straight_data_out_ready (data_out_1_ready)
    );

    // Accepted block goes out straight now and is queued on the skip side by the next edge
    a_fork_both: assert property (@(posedge clk) disable iff (reset)
        (data_in_0_valid && data_in_0_ready)
            |-> (data_out_1_valid && data_out_1_ready) ##1 data_out_0_valid)
        else $error("fork branches out of step");

endmodule

//--- source/mxint_macros.svh
`ifndef MXINT_MACROS_SVH
`define MXINT_MACROS_SVH

// Mantissa width, signed two's complement
`define MX_MAN_WIDTH 8

// Shared exponent width, unsigned
`define MX_EXP_WIDTH 8

// Mantissas per block
`define MX_BLOCK 4

// Skip path buffering in blocks
`define MX_FIFO_DEPTH 4

`endif

//--- source/mxint_pkg.sv
`include "mxint_macros.svh"

package mxint_pkg;

    // One signed mantissa lane
    typedef logic signed [`MX_MAN_WIDTH-1:0] man_t;

    // Shared block exponent
    typedef logic [`MX_EXP_WIDTH-1:0] exp_t;

    // Exponent in the top bits, lane 0 in the lowest bits
    typedef struct packed {
        exp_t                  exp;
        man_t [`MX_BLOCK-1:0]  man;
    } mx_block_t;

endpackage

//--- source/mxint_relu.sv
`include "mxint_macros.svh"

module mxint_relu (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output mxint_pkg::mx_block_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import mxint_pkg::*;

    mx_block_t relu_data;
    mx_block_t data_q;
    logic      valid_q;

    // Negative lanes clamp to zero, exponent untouched
    always_comb begin
        relu_data.exp = in_data.exp;
        for (int i = 0; i < `MX_BLOCK; i++) begin
            relu_data.man[i] = in_data.man[i][`MX_MAN_WIDTH-1] ? '0 : in_data.man[i];
        end
    end

    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= relu_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    a_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("relu output changed while stalled");

endmodule

//--- source/mxint_residual_top.sv
module mxint_residual_top (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output mxint_pkg::mx_block_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import mxint_pkg::*;

    mx_block_t skip_data;
    logic      skip_valid;
    logic      skip_ready;
    mx_block_t straight_data;
    logic      straight_valid;
    logic      straight_ready;
    mx_block_t relu_data;
    logic      relu_valid;
    logic      relu_ready;

    mxint_fork2 u_fork (
        .clk              (clk),
        .reset            (reset),
        .data_in_0        (in_data),
        .data_in_0_valid  (in_valid),
        .data_in_0_ready  (in_ready),
        .data_out_0       (skip_data),
        .data_out_0_valid (skip_valid),
        .data_out_0_ready (skip_ready),
        .data_out_1       (straight_data),
        .data_out_1_valid (straight_valid),
        .data_out_1_ready (straight_ready)
    );

    mxint_relu u_relu (
        .clk       (clk),
        .reset     (reset),
        .in_data   (straight_data),
        .in_valid  (straight_valid),
        .in_ready  (straight_ready),
        .out_data  (relu_data),
        .out_valid (relu_valid),
        .out_ready (relu_ready)
    );

    // Residual join
    mxint_add u_add (
        .clk          (clk),
        .reset        (reset),
        .skip         (skip_data),
        .skip_valid   (skip_valid),
        .skip_ready   (skip_ready),
        .branch       (relu_data),
        .branch_valid (relu_valid),
        .branch_ready (relu_ready),
        .sum          (out_data),
        .sum_valid    (out_valid),
        .sum_ready    (out_ready)
    );

endmodule

//--- source/split2_with_data.sv
module split2_with_data (
    input  logic                 clk,
    input  logic                 reset,

    input  mxint_pkg::mx_block_t data_in,
    input  logic                 data_in_valid,
    output logic                 data_in_ready,

    output mxint_pkg::mx_block_t fifo_data_out,
    output logic                 fifo_data_out_valid,
    input  logic                 fifo_data_out_ready,

    output mxint_pkg::mx_block_t straight_data_out,
    output logic                 straight_data_out_valid,
    input  logic                 straight_data_out_ready
);

    logic fifo_in_valid;
    logic fifo_in_ready;

    // Input leaves only when both branches take it on the same edge
    assign data_in_ready = fifo_in_ready && straight_data_out_ready;

    // Each branch sees valid only while the other one can accept
    assign fifo_in_valid           = data_in_valid && straight_data_out_ready;
    assign straight_data_out_valid = data_in_valid && fifo_in_ready;
    assign straight_data_out       = data_in;

    // Skip branch buffer, absorbs a slow skip consumer
    block_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (data_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_data_out),
        .out_valid (fifo_data_out_valid),
        .out_ready (fifo_data_out_ready)
    );

endmodule

//--- tests/mxint_residual_tb.sv
module mxint_residual_tb;
    import mxint_pkg::*;

    localparam int NUM_TESTS   = 12;
    localparam int NUM_PHASES  = 2;
    localparam int CYCLE_LIMIT = 40 * NUM_TESTS * NUM_PHASES + 100;
    localparam int PERIOD      = 100;

    logic      clk;
    logic      reset;
    mx_block_t in_data;
    logic      in_valid;
    logic      in_ready;
    mx_block_t out_data;
    logic      out_valid;
    logic      out_ready;

    // Test id, input block, expected block
    logic [87:0] vectors [NUM_TESTS];

    int     cycle;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     results_seen;
    longint first_accept_time;

    mxint_residual_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    function automatic logic [31:0] lcg_step(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [39:0] expected,
                                 input logic [39:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_vectors(input bit gaps);
        logic [31:0] rnd;
        rnd = 32'h974d;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(negedge clk);
            rnd = lcg_step(rnd);
            // Idle cycles ahead of the block
            while (gaps && rnd[17:16] == 2'b00) begin
                in_valid = 1'b0;
                @(negedge clk);
                rnd = lcg_step(rnd);
            end
            in_data  = vectors[i][79:40];
            in_valid = 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            if (i == 0) begin
                first_accept_time = $time;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_results(input bit stalls, input string phase);
        logic [31:0] rnd;
        longint      prev_time;
        int          count;
        string       name;
        bit          ok;
        bit          lat_ok;
        rnd = 32'h974d;
        count = 0;
        prev_time = 0;
        while (count < NUM_TESTS) begin
            @(negedge clk);
            rnd = lcg_step(rnd);
            out_ready = stalls ? (rnd[25:24] != 2'b00) : 1'b1;
            @(posedge clk);
            if (out_valid && out_ready) begin
                name = $sformatf("test %02h %s", vectors[count][87:80], phase);
                compare_value(name, vectors[count][39:0], out_data, ok);
                if (!stalls) begin
                    // Two cycles to the first result, then one per cycle
                    if (count == 0) begin
                        compare_value({name, " latency"}, 40'd2,
                                      40'(($time - first_accept_time) / PERIOD), lat_ok);
                    end else begin
                        compare_value({name, " spacing"}, 40'd1,
                                      40'(($time - prev_time) / PERIOD), lat_ok);
                    end
                    ok = ok && lat_ok;
                end
                prev_time = $time;
                if (ok) begin
                    tests_passed++;
                end else begin
                    tests_failed++;
                end
                $display("%s %s", name, ok ? "passed" : "failed");
                count++;
                results_seen++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        cycle = 0;
        while (cycle < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d cycles, %0d of %0d results received",
                 cycle, results_seen, NUM_TESTS * NUM_PHASES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        bit ok;
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        results_seen = 0;
        first_accept_time = 0;
        $readmemh("tests/mxint_residual_tests.txt", vectors);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if ($isunknown(vectors[i])) begin
                $display("Test vector %0d is missing or malformed in the data file", i);
                errors++;
            end
        end

        // Output stays idle while reset is held
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            compare_value($sformatf("reset cycle %0d out_valid", i), 40'd0,
                          40'(out_valid), ok);
        end
        reset = 1'b0;

        fork
            drive_vectors(1'b0);
            collect_results(1'b0, "steady");
        join
        fork
            drive_vectors(1'b1);
            collect_results(1'b1, "stall");
        join

        @(negedge clk);
        out_ready = 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (out_valid) begin
                $display("Extra result came out after the last expected block");
                errors++;
            end
        end

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tests/mxint_residual_tests.txt
// Columns: test id (2 hex), input block exp + man[3..0] (10 hex),
// expected output block exp + man[3..0] (10 hex)
01_10_01020304_11_01020304
02_00_7f7f7f7f_01_7f7f7f7f
03_20_80808080_21_c0c0c0c0
04_05_fffefd81_06_fffffec0
05_7f_40c0009c_80_40e000ce
06_fd_12ed7e83_fe_12f67ec1
07_01_00000000_02_00000000
08_33_55aa0ff0_34_55d50ff8
09_80_01ff7f80_81_01ff7fc0
0a_44_9d63e719_45_ce63f319
0b_0f_fe02c13f_10_ff02e03f
0c_c8_81807f01_c9_c0c07f01
